// File: Makefile
# Verilator build and run for the TileLink width bridge.

VERILATOR ?= verilator
TOP       ?= tl_downsize_tb
# 32'hefb946bf in decimal.
SEED      ?= 4021896895
FILELIST  ?= tl_downsize_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP SEED FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSeed=$(SEED) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)

// File: logic/tl_burst_tracker.sv
`timescale 1ns/1ps

module tl_burst_tracker (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  input  logic [tl_pkg::SizeWidth-1:0]     a_size_i,
  input  tl_pkg::tl_a_op_e                 a_opcode_i,
  input  logic                             a_fire_i,

  input  logic [tl_pkg::SizeWidth-1:0]     d_size_i,
  input  tl_pkg::tl_d_op_e                 d_opcode_i,
  input  logic                             d_fire_i,

  output logic [tl_pkg::BurstLenWidth-1:0] a_idx_o,
  output logic [tl_pkg::BurstLenWidth-1:0] a_left_o,
  output logic [tl_pkg::BurstLenWidth-1:0] d_len_o,
  output logic [tl_pkg::BurstLenWidth-1:0] d_idx_o,
  output logic [tl_pkg::BurstLenWidth-1:0] d_left_o
);

  // Slot 0 tracks the A channel and slot 1 tracks the D channel.
  // Both counters follow the same rules, so they share one loop.
  logic [1:0][tl_pkg::BurstLenWidth-1:0] len;
  logic [1:0][tl_pkg::BurstLenWidth-1:0] idx_q;
  logic [1:0][tl_pkg::BurstLenWidth-1:0] left;
  logic [1:0]                            fire;

  // Only data-carrying messages form multi-beat bursts.
  // A Get is a single A beat whatever its size.
  assign len[0] = (a_opcode_i != tl_pkg::Get) ? tl_pkg::burst_len(a_size_i) : '0;
  assign len[1] = (d_opcode_i == tl_pkg::AccessAckData) ? tl_pkg::burst_len(d_size_i) : '0;

  assign fire = {d_fire_i, a_fire_i};

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      left[i] = len[i] - idx_q[i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (fire[i]) begin
          // Wrap back to zero on the last beat of a burst.
          idx_q[i] <= (left[i] == '0) ? '0 : idx_q[i] + 1'b1;
        end
      end
    end
  end

  assign a_idx_o  = idx_q[0];
  assign a_left_o = left[0];
  assign d_len_o  = len[1];
  assign d_idx_o  = idx_q[1];
  assign d_left_o = left[1];

endmodule

// File: logic/tl_data_downsizer.sv
`timescale 1ns/1ps

module tl_data_downsizer (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  tl_pkg::tl_h2d_a_t  host_a_i,
  input  logic               host_a_valid_i,
  output logic               host_a_ready_o,

  output tl_pkg::tl_d2h_a_t  dev_a_o,
  output logic               dev_a_valid_o,
  input  logic               dev_a_ready_i,

  input  tl_pkg::tl_d_dev_t  dev_d_i,
  input  logic               dev_d_valid_i,
  output logic               dev_d_ready_o,

  output tl_pkg::tl_d_host_t host_d_o,
  output logic               host_d_valid_o,
  input  logic               host_d_ready_i
);

  logic [tl_pkg::BurstLenWidth-1:0] a_idx;
  logic [tl_pkg::BurstLenWidth-1:0] a_left;
  logic [tl_pkg::BurstLenWidth-1:0] d_len;
  logic [tl_pkg::BurstLenWidth-1:0] d_idx;
  logic [tl_pkg::BurstLenWidth-1:0] d_left;

  // The tracker sees the device side, where every beat is one word.
  tl_burst_tracker u_tracker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .a_size_i   (dev_a_o.size),
    .a_opcode_i (dev_a_o.opcode),
    .a_fire_i   (dev_a_valid_o && dev_a_ready_i),
    .d_size_i   (dev_d_i.size),
    .d_opcode_i (dev_d_i.opcode),
    .d_fire_i   (dev_d_valid_i && dev_d_ready_o),
    .a_idx_o    (a_idx),
    .a_left_o   (a_left),
    .d_len_o    (d_len),
    .d_idx_o    (d_idx),
    .d_left_o   (d_left)
  );

  ////////////////////////////////////////
  // A channel split
  ////////////////////////////////////////

  logic [tl_pkg::SubbeatNum-1:0][tl_pkg::DeviceDataWidth-1:0]   a_data_split;
  logic [tl_pkg::SubbeatNum-1:0][tl_pkg::DeviceDataWidth/8-1:0] a_mask_split;
  logic [tl_pkg::SubbeatBits-1:0]                               a_sel;

  assign a_data_split = host_a_i.data;
  assign a_mask_split = host_a_i.mask;

  // Transfers are size aligned, so the OR acts as an add of the start half
  // and the sub-beat index within the host beat.
  assign a_sel = host_a_i.address[tl_pkg::HostNonBurstSize-1:tl_pkg::DeviceNonBurstSize]
               | a_idx[tl_pkg::SubbeatBits-1:0];

  // The host beat is retired only with its last sub-beat.
  // This relies on the register slice holding the payload steady.
  assign host_a_ready_o = dev_a_ready_i && host_a_valid_i &&
                          (a_left[tl_pkg::SubbeatBits-1:0] == '0);
  assign dev_a_valid_o  = host_a_valid_i;

  always_comb begin
    dev_a_o.opcode  = host_a_i.opcode;
    dev_a_o.param   = host_a_i.param;
    dev_a_o.size    = host_a_i.size;
    dev_a_o.source  = host_a_i.source;
    dev_a_o.address = host_a_i.address;
    dev_a_o.mask    = a_mask_split[a_sel];
    dev_a_o.corrupt = host_a_i.corrupt;
    dev_a_o.data    = a_data_split[a_sel];
  end

  ////////////////////////////////////////
  // D channel gather
  ////////////////////////////////////////

  logic [tl_pkg::DeviceDataWidth-1:0] d_data_q;
  logic [tl_pkg::DeviceDataWidth-1:0] d_data_d;
  logic                               d_corrupt_q;
  logic                               d_corrupt_d;
  logic                               d_last;

  assign d_last = (d_left[tl_pkg::SubbeatBits-1:0] == '0);

  always_comb begin
    d_data_d    = d_data_q;
    d_corrupt_d = d_corrupt_q | dev_d_i.corrupt;
    // Lower half index zero, masked by the burst length. A single beat
    // response matches here too, which tiles it into both halves.
    if ((d_idx[tl_pkg::SubbeatBits-1:0] & d_len[tl_pkg::SubbeatBits-1:0]) == '0) begin
      d_data_d = dev_d_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d_corrupt_q <= 1'b0;
    end else if (dev_d_valid_i && dev_d_ready_o) begin
      // The sticky flag restarts with every host beat.
      d_corrupt_q <= d_last ? 1'b0 : d_corrupt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dev_d_valid_i && dev_d_ready_o) begin
      d_data_q <= d_data_d;
    end
  end

  // Early sub-beats are absorbed at once; the last waits for the host.
  assign dev_d_ready_o  = d_last ? host_d_ready_i : 1'b1;
  assign host_d_valid_o = dev_d_valid_i && d_last;

  always_comb begin
    host_d_o.opcode  = dev_d_i.opcode;
    host_d_o.param   = dev_d_i.param;
    host_d_o.size    = dev_d_i.size;
    host_d_o.source  = dev_d_i.source;
    host_d_o.sink    = dev_d_i.sink;
    host_d_o.denied  = dev_d_i.denied;
    host_d_o.corrupt = d_corrupt_d;
    host_d_o.data    = {dev_d_i.data, d_data_d};
  end

endmodule

// File: logic/tl_downsize_top.sv
`timescale 1ns/1ps

module tl_downsize_top (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  tl_pkg::tl_h2d_a_t  host_a_i,
  input  logic               host_a_valid_i,
  output logic               host_a_ready_o,

  output tl_pkg::tl_d_host_t host_d_o,
  output logic               host_d_valid_o,
  input  logic               host_d_ready_i
);

  // Registered host A into the downsizer.
  tl_pkg::tl_h2d_a_t  reg_a;
  logic               reg_a_valid;
  logic               reg_a_ready;

  // Gathered host D back through the slice.
  tl_pkg::tl_d_host_t ds_d;
  logic               ds_d_valid;
  logic               ds_d_ready;

  // Device side between downsizer and RAM.
  tl_pkg::tl_d2h_a_t  dev_a;
  logic               dev_a_valid;
  logic               dev_a_ready;
  tl_pkg::tl_d_dev_t  dev_d;
  logic               dev_d_valid;
  logic               dev_d_ready;

  tl_regslice u_regslice (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .host_a_i       (host_a_i),
    .host_a_valid_i (host_a_valid_i),
    .host_a_ready_o (host_a_ready_o),
    .out_a_o        (reg_a),
    .out_a_valid_o  (reg_a_valid),
    .out_a_ready_i  (reg_a_ready),
    .in_d_i         (ds_d),
    .in_d_valid_i   (ds_d_valid),
    .in_d_ready_o   (ds_d_ready),
    .host_d_o       (host_d_o),
    .host_d_valid_o (host_d_valid_o),
    .host_d_ready_i (host_d_ready_i)
  );

  tl_data_downsizer u_downsizer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .host_a_i       (reg_a),
    .host_a_valid_i (reg_a_valid),
    .host_a_ready_o (reg_a_ready),
    .dev_a_o        (dev_a),
    .dev_a_valid_o  (dev_a_valid),
    .dev_a_ready_i  (dev_a_ready),
    .dev_d_i        (dev_d),
    .dev_d_valid_i  (dev_d_valid),
    .dev_d_ready_o  (dev_d_ready),
    .host_d_o       (ds_d),
    .host_d_valid_o (ds_d_valid),
    .host_d_ready_i (ds_d_ready)
  );

  tl_ram_device u_ram (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .a_i       (dev_a),
    .a_valid_i (dev_a_valid),
    .a_ready_o (dev_a_ready),
    .d_o       (dev_d),
    .d_valid_o (dev_d_valid),
    .d_ready_i (dev_d_ready)
  );

endmodule

// File: logic/tl_pkg.sv
package tl_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int unsigned HostDataWidth   = 64;
  localparam int unsigned DeviceDataWidth = 32;
  localparam int unsigned AddrWidth       = 16;
  localparam int unsigned SourceWidth     = 2;
  localparam int unsigned SinkWidth       = 1;
  localparam int unsigned MaxSize         = 4;
  // The size field must be able to hold MaxSize.
  localparam int unsigned SizeWidth       = 3;

  // Log2 of the bytes carried by one beat on each side.
  localparam int unsigned DeviceNonBurstSize = 2;
  localparam int unsigned HostNonBurstSize   = 3;

  localparam int unsigned SubbeatNum        = HostDataWidth / DeviceDataWidth;
  localparam int unsigned SubbeatBits       = HostNonBurstSize - DeviceNonBurstSize;
  localparam int unsigned DeviceMaxBurstLen = 2 ** (MaxSize - DeviceNonBurstSize);
  localparam int unsigned BurstLenWidth     = $clog2(DeviceMaxBurstLen);

  // Depth of the memory device in device words.
  localparam int unsigned RamWords     = 64;
  localparam int unsigned RamAddrWidth = $clog2(RamWords);

  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  ////////////////////////////////////////
  // Channel payloads
  ////////////////////////////////////////

  typedef struct packed {
    tl_a_op_e                    opcode;
    logic [2:0]                  param;
    logic [SizeWidth-1:0]        size;
    logic [SourceWidth-1:0]      source;
    logic [AddrWidth-1:0]        address;
    logic [HostDataWidth/8-1:0]  mask;
    logic                        corrupt;
    logic [HostDataWidth-1:0]    data;
  } tl_h2d_a_t;

  typedef struct packed {
    tl_a_op_e                     opcode;
    logic [2:0]                   param;
    logic [SizeWidth-1:0]         size;
    logic [SourceWidth-1:0]       source;
    logic [AddrWidth-1:0]         address;
    logic [DeviceDataWidth/8-1:0] mask;
    logic                         corrupt;
    logic [DeviceDataWidth-1:0]   data;
  } tl_d2h_a_t;

  typedef struct packed {
    tl_d_op_e                   opcode;
    logic [2:0]                 param;
    logic [SizeWidth-1:0]       size;
    logic [SourceWidth-1:0]     source;
    logic [SinkWidth-1:0]       sink;
    logic                       denied;
    logic                       corrupt;
    logic [DeviceDataWidth-1:0] data;
  } tl_d_dev_t;

  typedef struct packed {
    tl_d_op_e                 opcode;
    logic [2:0]               param;
    logic [SizeWidth-1:0]     size;
    logic [SourceWidth-1:0]   source;
    logic [SinkWidth-1:0]     sink;
    logic                     denied;
    logic                     corrupt;
    logic [HostDataWidth-1:0] data;
  } tl_d_host_t;

  // Number of device beats in a burst of the given size, minus one.
  // Transfers that fit into one device word give zero.
  function automatic logic [BurstLenWidth-1:0] burst_len(input logic [SizeWidth-1:0] size);
    int unsigned beats;
    beats = 1;
    if (size > DeviceNonBurstSize) begin
      beats = 1 << (size - DeviceNonBurstSize);
    end
    return BurstLenWidth'(beats - 1);
  endfunction

endpackage

// File: logic/tl_ram_device.sv
`timescale 1ns/1ps

module tl_ram_device (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  tl_pkg::tl_d2h_a_t a_i,
  input  logic              a_valid_i,
  output logic              a_ready_o,

  output tl_pkg::tl_d_dev_t d_o,
  output logic              d_valid_o,
  input  logic              d_ready_i
);

  logic [tl_pkg::DeviceDataWidth-1:0] mem [tl_pkg::RamWords];

  // Response state. The channel is busy for as long as D is valid.
  logic                              d_valid_q;
  tl_pkg::tl_d_op_e                  d_op_q;
  logic [tl_pkg::SizeWidth-1:0]      d_size_q;
  logic [tl_pkg::SourceWidth-1:0]    d_source_q;
  logic                              d_denied_q;
  logic [tl_pkg::RamAddrWidth-1:0]   d_base_q;
  logic [tl_pkg::BurstLenWidth-1:0]  d_beat_q;
  logic [tl_pkg::BurstLenWidth-1:0]  d_last_q;

  // Beat counter for incoming Put bursts.
  logic [tl_pkg::BurstLenWidth-1:0]  a_beat_q;

  logic                              a_fire;
  logic                              a_denied;
  logic                              a_put;
  logic [tl_pkg::BurstLenWidth-1:0]  a_len;
  logic [tl_pkg::RamAddrWidth-1:0]   a_base;
  logic [tl_pkg::RamAddrWidth-1:0]   a_word;

  assign a_ready_o = !d_valid_q;
  assign a_fire    = a_valid_i && a_ready_o;
  assign a_put     = (a_i.opcode != tl_pkg::Get);
  assign a_len     = tl_pkg::burst_len(a_i.size);
  assign a_denied  = (a_i.address >= tl_pkg::AddrWidth'(tl_pkg::RamWords * 4));
  assign a_base    = a_i.address[tl_pkg::DeviceNonBurstSize +: tl_pkg::RamAddrWidth];
  assign a_word    = a_base + tl_pkg::RamAddrWidth'(a_beat_q);

  // Byte-masked write, skipped entirely for denied addresses.
  always_ff @(posedge clk_i) begin
    if (a_fire && a_put && !a_denied) begin
      for (int b = 0; b < tl_pkg::DeviceDataWidth / 8; b++) begin
        if (a_i.mask[b]) begin
          mem[a_word][8*b +: 8] <= a_i.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d_valid_q <= 1'b0;
      a_beat_q  <= '0;
      d_beat_q  <= '0;
    end else if (a_fire) begin
      if (!a_put || a_beat_q == a_len) begin
        // Last request beat, so the response starts next cycle.
        d_valid_q <= 1'b1;
        a_beat_q  <= '0;
        d_beat_q  <= '0;
      end else begin
        a_beat_q <= a_beat_q + 1'b1;
      end
    end else if (d_valid_q && d_ready_i) begin
      if (d_op_q == tl_pkg::AccessAckData && d_beat_q != d_last_q) begin
        d_beat_q <= d_beat_q + 1'b1;
      end else begin
        d_valid_q <= 1'b0;
      end
    end
  end

  // Response fields latch with each request beat; only the final one counts.
  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      d_op_q     <= a_put ? tl_pkg::AccessAck : tl_pkg::AccessAckData;
      d_size_q   <= a_i.size;
      d_source_q <= a_i.source;
      d_denied_q <= a_denied;
      d_base_q   <= a_base;
      d_last_q   <= a_len;
    end
  end

  assign d_valid_o = d_valid_q;

  always_comb begin
    d_o.opcode  = d_op_q;
    d_o.param   = '0;
    d_o.size    = d_size_q;
    d_o.source  = d_source_q;
    d_o.sink    = '0;
    d_o.denied  = d_denied_q;
    // A denied Get carries no valid data.
    d_o.corrupt = d_denied_q && (d_op_q == tl_pkg::AccessAckData);
    d_o.data    = d_denied_q ? '0 : mem[d_base_q + tl_pkg::RamAddrWidth'(d_beat_q)];
  end

endmodule

// File: logic/tl_regslice.sv
`timescale 1ns/1ps

module tl_regslice (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  tl_pkg::tl_h2d_a_t  host_a_i,
  input  logic               host_a_valid_i,
  output logic               host_a_ready_o,

  output tl_pkg::tl_h2d_a_t  out_a_o,
  output logic               out_a_valid_o,
  input  logic               out_a_ready_i,

  input  tl_pkg::tl_d_host_t in_d_i,
  input  logic               in_d_valid_i,
  output logic               in_d_ready_o,

  output tl_pkg::tl_d_host_t host_d_o,
  output logic               host_d_valid_o,
  input  logic               host_d_ready_i
);

  ////////////////////////////////////////
  // A channel register
  ////////////////////////////////////////

  tl_pkg::tl_h2d_a_t a_q;
  logic              a_valid_q;

  // The slot can take a new beat when it is empty or drains this cycle.
  assign host_a_ready_o = !a_valid_q || out_a_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_valid_q <= 1'b0;
    end else if (host_a_ready_o) begin
      a_valid_q <= host_a_valid_i;
    end
  end

  // The payload only moves when a beat is actually taken.
  always_ff @(posedge clk_i) begin
    if (host_a_ready_o && host_a_valid_i) begin
      a_q <= host_a_i;
    end
  end

  assign out_a_o       = a_q;
  assign out_a_valid_o = a_valid_q;

  // D needs no decoupling here, so it passes through untouched.
  assign host_d_o       = in_d_i;
  assign host_d_valid_o = in_d_valid_i;
  assign in_d_ready_o   = host_d_ready_i;

endmodule

// File: sim/tl_downsize_tb.sv
`timescale 1ns/1ps

module tl_downsize_tb #(
  parameter int unsigned Seed = 32'hefb946bf
);

  localparam int unsigned ClkPeriod = 10;
  // Roughly 200 requests of up to 20 cycles each, plus margin for back-pressure.
  localparam int unsigned MaxCycles = 6000;
  localparam int unsigned RamBytes  = tl_pkg::RamWords * 4;

  // One host D beat as the reference model predicts it.
  typedef struct packed {
    tl_pkg::tl_d_op_e                 opcode;
    logic [tl_pkg::SizeWidth-1:0]     size;
    logic [tl_pkg::SourceWidth-1:0]   source;
    logic                             denied;
    logic                             corrupt;
    logic                             has_data;
    logic [tl_pkg::HostDataWidth-1:0] data;
  } exp_beat_t;

  logic               clk;
  logic               rst_n;
  tl_pkg::tl_h2d_a_t  host_a;
  logic               host_a_valid;
  logic               host_a_ready;
  tl_pkg::tl_d_host_t host_d;
  logic               host_d_valid;
  logic               host_d_ready;

  // Byte-level image of the RAM, plus the responses still owed.
  logic [7:0]  ref_mem [RamBytes];
  exp_beat_t   exp_q [$];
  logic        toggle_ready;
  int unsigned cycle_count;

  tl_downsize_top dut0 (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .host_a_i       (host_a),
    .host_a_valid_i (host_a_valid),
    .host_a_ready_o (host_a_ready),
    .host_d_o       (host_d),
    .host_d_valid_o (host_d_valid),
    .host_d_ready_i (host_d_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
    assert (got === want)
      else fail_run($sformatf("mismatch %s expected 0x%0h got 0x%0h", name, want, got));
  endtask

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count >= MaxCycles) begin
        fail_run($sformatf("timeout after %0d cycles, the test sequence never finished",
                           cycle_count));
      end
    end
  end

  // Host D ready is either held high or flipped at random each cycle.
  initial begin
    host_d_ready = 1'b1;
    forever begin
      @(negedge clk);
      host_d_ready = toggle_ready ? 1'($urandom_range(0, 1)) : 1'b1;
    end
  end

  ////////////////////////////////////////
  // Response checking
  ////////////////////////////////////////

  // A stalled response must hold its payload until the host takes it.
  assert property (@(posedge clk) disable iff (!rst_n)
      host_d_valid && !host_d_ready |=> host_d_valid && $stable(host_d))
    else fail_run("host D payload changed while it waited for ready");

  always @(posedge clk) begin
    exp_beat_t want;
    if (rst_n && host_d_valid && host_d_ready) begin
      assert (exp_q.size() != 0)
        else fail_run("host D delivered a beat while no response was outstanding");
      if (exp_q.size() != 0) begin
        want = exp_q.pop_front();
        check_value("host_d.opcode", 64'(host_d.opcode), 64'(want.opcode));
        // Neither AccessAck nor AccessAckData defines a param value.
        check_value("host_d.param", 64'(host_d.param), 64'(3'b000));
        check_value("host_d.size", 64'(host_d.size), 64'(want.size));
        check_value("host_d.source", 64'(host_d.source), 64'(want.source));
        check_value("host_d.denied", 64'(host_d.denied), 64'(want.denied));
        check_value("host_d.corrupt", 64'(host_d.corrupt), 64'(want.corrupt));
        // Denied reads carry no meaningful data.
        if (want.has_data) begin
          check_value("host_d.data", host_d.data, want.data);
        end
      end
    end
  end

  ////////////////////////////////////////
  // Reference memory and host driver
  ////////////////////////////////////////

  function automatic logic [63:0] ref_line(input int unsigned base);
    logic [63:0] line;
    for (int i = 0; i < 8; i++) begin
      line[8*i +: 8] = ref_mem[base + i];
    end
    return line;
  endfunction

  task automatic ref_write(input int unsigned base, input logic [63:0] data,
                           input logic [7:0] mask);
    for (int i = 0; i < 8; i++) begin
      if (mask[i]) begin
        ref_mem[base + i] = data[8*i +: 8];
      end
    end
  endtask

  // Called on a falling edge; returns on the falling edge after the beat is taken.
  task automatic send_beat(input tl_pkg::tl_h2d_a_t beat);
    host_a       = beat;
    host_a_valid = 1'b1;
    do begin
      @(posedge clk);
    end while (!host_a_ready);
    @(negedge clk);
  endtask

  task automatic run_request(input tl_pkg::tl_a_op_e op, input logic [2:0] size,
                             input logic [15:0] addr, input logic [1:0][63:0] data,
                             input logic [1:0][7:0] mask);
    tl_pkg::tl_h2d_a_t beat;
    exp_beat_t         want;
    logic              denied;
    logic [63:0]       line;
    int unsigned       base;
    int unsigned       beats;

    denied      = (addr >= RamBytes);
    base        = 32'({addr[15:3], 3'b000});
    beats       = (size == 3'd4) ? 2 : 1;
    want        = '0;
    want.size   = size;
    want.source = 2'($urandom_range(0, 3));
    want.denied = denied;
    // Expected responses are queued before the request goes out.
    if (op == tl_pkg::Get) begin
      want.opcode   = tl_pkg::AccessAckData;
      want.corrupt  = denied;
      want.has_data = !denied;
      for (int k = 0; k < beats; k++) begin
        if (!denied) begin
          line = ref_line(base + 8 * k);
          // A single word comes back in both halves.
          if (size == 3'd2) begin
            line = addr[2] ? {2{line[63:32]}} : {2{line[31:0]}};
          end
          want.data = line;
        end
        exp_q.push_back(want);
      end
    end else begin
      want.opcode = tl_pkg::AccessAck;
      for (int k = 0; k < beats; k++) begin
        if (!denied) begin
          ref_write(base + 8 * k, data[k], mask[k]);
        end
      end
      exp_q.push_back(want);
    end
    beat         = '0;
    beat.opcode  = op;
    beat.size    = size;
    beat.source  = want.source;
    beat.address = addr;
    for (int k = 0; k < ((op == tl_pkg::Get) ? 1 : beats); k++) begin
      beat.data = data[k];
      beat.mask = mask[k];
      send_beat(beat);
    end
    host_a_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic random_request();
    tl_pkg::tl_a_op_e op;
    logic [2:0]       size;
    logic [15:0]      addr;
    logic [1:0][63:0] data;
    logic [1:0][7:0]  mask;
    logic [7:0]       lanes;
    int unsigned      pick;

    pick = $urandom_range(0, 2);
    op   = (pick == 0) ? tl_pkg::PutFullData :
           (pick == 1) ? tl_pkg::PutPartialData : tl_pkg::Get;
    size = 3'($urandom_range(2, 4));
    addr = 16'($urandom_range(0, RamBytes - 1)) & ~((16'd1 << size) - 16'd1);
    // About one request in sixteen lands above the RAM.
    if ($urandom_range(0, 15) == 0) begin
      addr = addr | 16'h0400;
    end
    lanes = (size == 3'd2) ? (addr[2] ? 8'hF0 : 8'h0F) : 8'hFF;
    for (int k = 0; k < 2; k++) begin
      data[k] = {$urandom, $urandom};
      mask[k] = (op == tl_pkg::PutPartialData) ? (lanes & 8'($urandom)) : lanes;
    end
    run_request(op, size, addr, data, mask);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [1:0][63:0] data;

    void'($urandom(Seed));
    toggle_ready = 1'b0;
    rst_n        = 1'b0;
    host_a       = '0;
    host_a_valid = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Every line gets a known value through 16-byte bursts.
    for (int a = 0; a < RamBytes; a += 16) begin
      data = {$urandom, $urandom, $urandom, $urandom};
      run_request(tl_pkg::PutFullData, 3'd4, 16'(a), data, {8'hFF, 8'hFF});
    end

    run_request(tl_pkg::PutFullData, 3'd3, 16'h0040, {64'h0, 64'h0123_4567_89ab_cdef},
                {8'h00, 8'hFF});
    run_request(tl_pkg::Get, 3'd3, 16'h0040, '0, '0);

    // Only the masked bytes change.
    run_request(tl_pkg::PutPartialData, 3'd3, 16'h0048, {64'h0, $urandom, $urandom},
                {8'h00, 8'($urandom)});
    run_request(tl_pkg::Get, 3'd3, 16'h0048, '0, '0);

    run_request(tl_pkg::Get, 3'd2, 16'h0050, '0, '0);
    run_request(tl_pkg::Get, 3'd2, 16'h0054, '0, '0);

    data = {$urandom, $urandom, $urandom, $urandom};
    run_request(tl_pkg::PutFullData, 3'd4, 16'h0060, data, {8'hFF, 8'hFF});
    run_request(tl_pkg::Get, 3'd4, 16'h0060, '0, '0);

    // The out of range Put aliases word 0 if it were ever written.
    run_request(tl_pkg::Get, 3'd3, 16'h0100, '0, '0);
    run_request(tl_pkg::PutFullData, 3'd3, 16'h0200, {64'h0, 64'hdead_beef_dead_beef},
                {8'h00, 8'hFF});
    run_request(tl_pkg::Get, 3'd3, 16'h0000, '0, '0);

    toggle_ready = 1'b1;
    repeat (150) random_request();
    // Read the whole RAM back under back-pressure.
    for (int a = 0; a < RamBytes; a += 16) begin
      run_request(tl_pkg::Get, 3'd4, 16'(a), '0, '0);
    end
    toggle_ready = 1'b0;

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: tl_downsize_top.f
logic/tl_pkg.sv
logic/tl_regslice.sv
logic/tl_burst_tracker.sv
logic/tl_data_downsizer.sv
logic/tl_ram_device.sv
logic/tl_downsize_top.sv
sim/tl_downsize_tb.sv
